// File: Makefile
TOP := conv_pe_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: common/pe_pkg.sv
package pe_pkg;

    localparam int DATA_W      = 8;
    localparam int COEF_W      = 8;
    localparam int IF_ADDR_W   = 6;
    localparam int FILT_ADDR_W = 4;
    localparam int PROD_W      = DATA_W + COEF_W;
    localparam int ACC_W       = 24;

    // Largest word count if_count can represent
    localparam int IF_MAX_WORDS = (1 << IF_ADDR_W) - 1;

    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [COEF_W-1:0]      coef_t;
    typedef logic [PROD_W-1:0]      prod_t;
    typedef logic [ACC_W-1:0]       acc_t;
    typedef logic [IF_ADDR_W-1:0]   if_addr_t;
    typedef logic [FILT_ADDR_W-1:0] filt_addr_t;

    // Loader states
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_READ,
        LD_DONE
    } load_state_e;

    // Address generator states
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_WAIT_DATA,
        GEN_RUN,
        GEN_DRAIN,
        GEN_FINISH
    } gen_state_e;

endpackage

// File: compile.f
common/pe_pkg.sv
hdl/scratch_ram.sv
hdl/ifmap_loader.sv
hdl/filter_loader.sv
hdl/read_addr_gen.sv
hdl/mac_pipeline.sv
hdl/outbuf_writer.sv
hdl/conv_pe_top.sv
sim/conv_pe_sva.sv
sim/conv_pe_tb.sv

// File: hdl/conv_pe_top.sv
`timescale 1ns/1ps

module conv_pe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ifmap_start,
    input  logic               filt_start,
    input  logic               conv_start,
    input  logic               ifmap_empty,
    input  logic               ifmap_last,
    input  pe_pkg::data_t      ifmap_data,
    input  logic               filt_empty,
    input  pe_pkg::coef_t      filt_data,
    input  pe_pkg::filt_addr_t filt_len,
    input  pe_pkg::if_addr_t   stride,
    input  pe_pkg::acc_t       psum_in,
    input  logic               psum_add_en,
    input  logic               out_full,
    output logic               ifmap_rd,
    output logic               filt_rd,
    output pe_pkg::acc_t       out_data,
    output logic               out_wr,
    output logic               psum_done,
    output logic               full_done,
    output logic               stride_count_flag
);

    import pe_pkg::*;

    logic       if_wr_en;
    if_addr_t   if_waddr;
    if_addr_t   if_count;
    logic       if_ready;
    logic       filt_wr_en;
    filt_addr_t filt_waddr;
    logic       filt_ready;
    if_addr_t   if_raddr;
    filt_addr_t filt_raddr;
    logic       rd_en;
    logic       tap_valid;
    logic       first_tap;
    logic       last_tap;
    data_t      if_rdata;
    coef_t      filt_rdata;
    acc_t       result;
    logic       result_valid;
    logic       stall;

    ifmap_loader u_ifmap_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .ifmap_start (ifmap_start),
        .ifmap_empty (ifmap_empty),
        .ifmap_last  (ifmap_last),
        .ifmap_rd    (ifmap_rd),
        .wr_en       (if_wr_en),
        .wr_addr     (if_waddr),
        .if_count    (if_count),
        .if_ready    (if_ready)
    );

    filter_loader u_filter_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .filt_start (filt_start),
        .filt_empty (filt_empty),
        .filt_len   (filt_len),
        .filt_rd    (filt_rd),
        .wr_en      (filt_wr_en),
        .wr_addr    (filt_waddr),
        .filt_ready (filt_ready)
    );

    scratch_ram #(
        .ADDR_W (IF_ADDR_W),
        .WIDTH  (DATA_W)
    ) u_if_scratch (
        .clk     (clk),
        .wr_en   (if_wr_en),
        .wr_addr (if_waddr),
        .wr_data (ifmap_data),
        .rd_en   (rd_en),
        .rd_addr (if_raddr),
        .rd_data (if_rdata)
    );

    scratch_ram #(
        .ADDR_W (FILT_ADDR_W),
        .WIDTH  (COEF_W)
    ) u_filt_scratch (
        .clk     (clk),
        .wr_en   (filt_wr_en),
        .wr_addr (filt_waddr),
        .wr_data (filt_data),
        .rd_en   (rd_en),
        .rd_addr (filt_raddr),
        .rd_data (filt_rdata)
    );

    read_addr_gen u_read_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .conv_start  (conv_start),
        .if_ready    (if_ready),
        .filt_ready  (filt_ready),
        .if_count    (if_count),
        .filt_len    (filt_len),
        .stride      (stride),
        .stall       (stall),
        .out_wr_last (out_wr),
        .if_raddr    (if_raddr),
        .filt_raddr  (filt_raddr),
        .rd_en       (rd_en),
        .tap_valid   (tap_valid),
        .first_tap   (first_tap),
        .last_tap    (last_tap),
        .run_active  (stride_count_flag),
        .full_done   (full_done)
    );

    mac_pipeline u_mac_pipeline (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .tap_valid    (tap_valid),
        .first_tap    (first_tap),
        .last_tap     (last_tap),
        .if_data      (if_rdata),
        .coef         (filt_rdata),
        .psum_in      (psum_in),
        .psum_add_en  (psum_add_en),
        .result       (result),
        .result_valid (result_valid)
    );

    outbuf_writer u_outbuf_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .result       (result),
        .result_valid (result_valid),
        .out_full     (out_full),
        .out_data     (out_data),
        .out_wr       (out_wr),
        .psum_done    (psum_done),
        .stall        (stall)
    );

endmodule

// File: hdl/filter_loader.sv
`timescale 1ns/1ps

module filter_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               filt_start,
    input  logic               filt_empty,
    input  pe_pkg::filt_addr_t filt_len,
    output logic               filt_rd,
    output logic               wr_en,
    output pe_pkg::filt_addr_t wr_addr,
    output logic               filt_ready
);

    import pe_pkg::*;

    load_state_e state;
    filt_addr_t  count;
    logic        rd_pend;

    assign filt_rd    = (state == LD_READ) && !rd_pend && !filt_empty;
    assign wr_en      = rd_pend;
    assign wr_addr    = count;
    assign filt_ready = (state == LD_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= LD_IDLE;
            rd_pend <= 1'b0;
            count   <= '0;
        end else if (filt_start) begin
            // Zero-length filter is ready at once
            state   <= (filt_len == '0) ? LD_DONE : LD_READ;
            rd_pend <= 1'b0;
            count   <= '0;
        end else begin
            rd_pend <= filt_rd;
            if (rd_pend) begin
                count <= count + 1'b1;
                if (filt_addr_t'(count + 1'b1) == filt_len) begin
                    state <= LD_DONE;
                end
            end
        end
    end

endmodule

// File: hdl/ifmap_loader.sv
`timescale 1ns/1ps

module ifmap_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ifmap_start,
    input  logic             ifmap_empty,
    input  logic             ifmap_last,
    output logic             ifmap_rd,
    output logic             wr_en,
    output pe_pkg::if_addr_t wr_addr,
    output pe_pkg::if_addr_t if_count,
    output logic             if_ready
);

    import pe_pkg::*;

    load_state_e state;
    logic        rd_pend;

    // At most one FIFO read in flight, word returns next cycle
    assign ifmap_rd = (state == LD_READ) && !rd_pend && !ifmap_empty;
    assign wr_en    = rd_pend;
    assign wr_addr  = if_count;
    assign if_ready = (state == LD_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= LD_IDLE;
            rd_pend  <= 1'b0;
            if_count <= '0;
        end else if (ifmap_start) begin
            state    <= LD_READ;
            rd_pend  <= 1'b0;
            if_count <= '0;
        end else begin
            rd_pend <= ifmap_rd;
            if (rd_pend) begin
                if_count <= if_count + 1'b1;
                // Last word of the stream, or scratchpad out of room
                if (ifmap_last || if_count == if_addr_t'(IF_MAX_WORDS - 1)) begin
                    state <= LD_DONE;
                end
            end
        end
    end

endmodule

// File: hdl/mac_pipeline.sv
`timescale 1ns/1ps

module mac_pipeline (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          tap_valid,
    input  logic          first_tap,
    input  logic          last_tap,
    input  pe_pkg::data_t if_data,
    input  pe_pkg::coef_t coef,
    input  pe_pkg::acc_t  psum_in,
    input  logic          psum_add_en,
    output pe_pkg::acc_t  result,
    output logic          result_valid
);

    import pe_pkg::*;

    logic  s1_valid;
    logic  s1_first;
    logic  s1_last;
    logic  s2_valid;
    logic  s2_first;
    logic  s2_last;
    logic  s3_done;
    prod_t prod_q;
    acc_t  acc_q;
    acc_t  acc_base;
    acc_t  psum_term;

    // First tap restarts the sum
    assign acc_base  = s2_first ? '0 : acc_q;
    assign psum_term = (s2_last && psum_add_en) ? psum_in : '0;

    // Tap flags, aligned with scratchpad data in s1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s1_first     <= 1'b0;
            s1_last      <= 1'b0;
            s2_valid     <= 1'b0;
            s2_first     <= 1'b0;
            s2_last      <= 1'b0;
            s3_done      <= 1'b0;
            result_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid     <= tap_valid;
            s1_first     <= tap_valid && first_tap;
            s1_last      <= tap_valid && last_tap;
            s2_valid     <= s1_valid;
            s2_first     <= s1_first;
            s2_last      <= s1_last;
            s3_done      <= s2_valid && s2_last;
            result_valid <= s3_done;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (s1_valid) begin
                prod_q <= prod_t'(if_data) * prod_t'(coef);
            end
            if (s2_valid) begin
                acc_q <= acc_base + acc_t'(prod_q) + psum_term;
            end
            // Snapshot before the next window overwrites acc_q
            if (s3_done) begin
                result <= acc_q;
            end
        end
    end

endmodule

// File: hdl/outbuf_writer.sv
`timescale 1ns/1ps

module outbuf_writer (
    input  logic         clk,
    input  logic         rst_n,
    input  pe_pkg::acc_t result,
    input  logic         result_valid,
    input  logic         out_full,
    output pe_pkg::acc_t out_data,
    output logic         out_wr,
    output logic         psum_done,
    output logic         stall
);

    import pe_pkg::*;

    acc_t hold_data;
    logic hold_valid;
    logic take;

    assign out_wr    = hold_valid && !out_full;
    assign psum_done = out_wr;
    assign out_data  = hold_data;

    // Full holding slot and no room downstream freezes the pipe
    assign stall = hold_valid && out_full;
    assign take  = result_valid && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (take) begin
            hold_valid <= 1'b1;
        end else if (out_wr) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_data <= result;
        end
    end

endmodule

// File: hdl/read_addr_gen.sv
`timescale 1ns/1ps

module read_addr_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               conv_start,
    input  logic               if_ready,
    input  logic               filt_ready,
    input  pe_pkg::if_addr_t   if_count,
    input  pe_pkg::filt_addr_t filt_len,
    input  pe_pkg::if_addr_t   stride,
    input  logic               stall,
    input  logic               out_wr_last,
    output pe_pkg::if_addr_t   if_raddr,
    output pe_pkg::filt_addr_t filt_raddr,
    output logic               rd_en,
    output logic               tap_valid,
    output logic               first_tap,
    output logic               last_tap,
    output logic               run_active,
    output logic               full_done
);

    import pe_pkg::*;

    gen_state_e           state;
    if_addr_t             base;
    filt_addr_t           tap;
    if_addr_t             pending;
    logic                 issue_last;
    // Two spare bits so the window end check cannot wrap
    logic [IF_ADDR_W+1:0] next_end;

    assign run_active = (state == GEN_RUN);
    assign tap_valid  = run_active;
    assign first_tap  = run_active && (tap == '0);
    assign last_tap   = run_active && (tap == filt_len - 1'b1);
    assign if_raddr   = base + if_addr_t'(tap);
    assign filt_raddr = tap;
    assign rd_en      = tap_valid && !stall;
    assign issue_last = last_tap && !stall;

    // End of the window after the current one
    assign next_end = (IF_ADDR_W+2)'(base) + (IF_ADDR_W+2)'(stride)
                    + (IF_ADDR_W+2)'(filt_len);

    // Last write of the run, nothing else in flight
    assign full_done = (state == GEN_DRAIN) && out_wr_last && (pending == if_addr_t'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= GEN_IDLE;
            base    <= '0;
            tap     <= '0;
            pending <= '0;
        end else begin
            // Windows issued but not yet written out
            case ({issue_last, out_wr_last})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase

            case (state)
                GEN_IDLE, GEN_FINISH: begin
                    state <= conv_start ? GEN_WAIT_DATA : GEN_IDLE;
                end
                GEN_WAIT_DATA: begin
                    base <= '0;
                    tap  <= '0;
                    if (if_ready && filt_ready) begin
                        // Too few words for even one window
                        if (filt_len == '0 || if_count < if_addr_t'(filt_len)) begin
                            state <= GEN_FINISH;
                        end else begin
                            state <= GEN_RUN;
                        end
                    end
                end
                GEN_RUN: begin
                    if (!stall) begin
                        if (last_tap) begin
                            tap  <= '0;
                            base <= base + stride;
                            if (next_end > (IF_ADDR_W+2)'(if_count)) begin
                                state <= GEN_DRAIN;
                            end
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                GEN_DRAIN: begin
                    if (full_done) begin
                        state <= GEN_FINISH;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
    parameter int ADDR_W = pe_pkg::IF_ADDR_W,
    parameter int WIDTH  = pe_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [WIDTH-1:0]  wr_data,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [WIDTH-1:0]  rd_data
);

    logic [WIDTH-1:0] mem [1 << ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Output holds while rd_en is low
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: sim/conv_pe_sva.sv
`timescale 1ns/1ps

module conv_pe_sva (
    input logic clk,
    input logic rst_n,
    input logic ifmap_rd,
    input logic ifmap_empty,
    input logic filt_rd,
    input logic filt_empty,
    input logic out_wr,
    input logic out_full,
    input logic psum_done,
    input logic full_done,
    input logic stride_count_flag,
    input logic stall,
    input logic if_ready,
    input logic filt_ready
);

    // Upstream FIFO reads
    a_ifmap_rd_has_data: assert property (
        @(posedge clk) disable iff (!rst_n) ifmap_rd |-> !ifmap_empty
    ) else $error("ifmap FIFO read issued while empty");

    a_filt_rd_has_data: assert property (
        @(posedge clk) disable iff (!rst_n) filt_rd |-> !filt_empty
    ) else $error("filter FIFO read issued while empty");

    // Downstream buffer
    a_wr_has_room: assert property (
        @(posedge clk) disable iff (!rst_n) out_wr |-> !out_full
    ) else $error("output buffer written while full");

    a_done_with_wr: assert property (
        @(posedge clk) disable iff (!rst_n) full_done |-> out_wr
    ) else $error("full_done without an output write");

    // One cycle of reset quiets every control output
    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |=> !(ifmap_rd || filt_rd || out_wr || psum_done || full_done
                                    || stride_count_flag || stall || if_ready || filt_ready)
    ) else $error("control output high after reset");

endmodule

bind conv_pe_top conv_pe_sva u_conv_pe_sva (
    .clk               (clk),
    .rst_n             (rst_n),
    .ifmap_rd          (ifmap_rd),
    .ifmap_empty       (ifmap_empty),
    .filt_rd           (filt_rd),
    .filt_empty        (filt_empty),
    .out_wr            (out_wr),
    .out_full          (out_full),
    .psum_done         (psum_done),
    .full_done         (full_done),
    .stride_count_flag (stride_count_flag),
    .stall             (stall),
    .if_ready          (if_ready),
    .filt_ready        (filt_ready)
);

// File: sim/conv_pe_tb.sv
`timescale 1ns/1ps

module conv_pe_tb;

    import pe_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    logic       clk         = 1'b0;
    logic       rst_n       = 1'b0;
    logic       ifmap_start = 1'b0;
    logic       filt_start  = 1'b0;
    logic       conv_start  = 1'b0;
    logic       ifmap_empty = 1'b1;
    logic       ifmap_last  = 1'b0;
    data_t      ifmap_data  = '0;
    logic       filt_empty  = 1'b1;
    coef_t      filt_data   = '0;
    filt_addr_t filt_len    = '0;
    if_addr_t   stride      = '0;
    acc_t       psum_in     = '0;
    logic       psum_add_en = 1'b0;
    logic       out_full    = 1'b0;
    logic       ifmap_rd;
    logic       filt_rd;
    acc_t       out_data;
    logic       out_wr;
    logic       psum_done;
    logic       full_done;
    logic       stride_count_flag;

    data_t  if_mem [64];
    coef_t  filt_mem [16];
    data_t  if_q [$];
    coef_t  filt_q [$];
    acc_t   exp_q [$];
    acc_t   exp_val;
    logic   if_rd_q;
    logic   filt_rd_q;
    logic   starve;
    logic   backpressure;
    string  test_name;
    int     errors;
    int     n_writes;
    int     n_done;
    int     tests_run;
    int     tests_failed;

    always #5 clk = ~clk;

    conv_pe_top u_conv_pe_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .ifmap_start       (ifmap_start),
        .filt_start        (filt_start),
        .conv_start        (conv_start),
        .ifmap_empty       (ifmap_empty),
        .ifmap_last        (ifmap_last),
        .ifmap_data        (ifmap_data),
        .filt_empty        (filt_empty),
        .filt_data         (filt_data),
        .filt_len          (filt_len),
        .stride            (stride),
        .psum_in           (psum_in),
        .psum_add_en       (psum_add_en),
        .out_full          (out_full),
        .ifmap_rd          (ifmap_rd),
        .filt_rd           (filt_rd),
        .out_data          (out_data),
        .out_wr            (out_wr),
        .psum_done         (psum_done),
        .full_done         (full_done),
        .stride_count_flag (stride_count_flag)
    );

    // FIFO models return the word the cycle after the strobe
    always @(negedge clk) begin
        if (if_rd_q && if_q.size() > 0) begin
            ifmap_data = if_q.pop_front();
            ifmap_last = (if_q.size() == 0);
        end
        if (filt_rd_q && filt_q.size() > 0) begin
            filt_data = filt_q.pop_front();
        end
        ifmap_empty = (if_q.size() == 0) || (starve && $urandom_range(0, 2) == 0);
        filt_empty  = (filt_q.size() == 0) || (starve && $urandom_range(0, 2) == 0);
        out_full    = backpressure && ($urandom_range(0, 1) == 1);
    end

    // Strobe capture and scoreboard
    always @(posedge clk) begin
        if_rd_q   <= ifmap_rd;
        filt_rd_q <= filt_rd;
        if (rst_n) begin
            assert (!(ifmap_rd && ifmap_empty) && !(filt_rd && filt_empty)) else begin
                $display("FIFO read issued while the FIFO was empty in test %s", test_name);
                errors++;
            end
            assert (psum_done == out_wr) else begin
                $display("psum_done did not pulse together with out_wr in test %s",
                         test_name);
                errors++;
            end
            if (out_wr) begin
                n_writes++;
                assert (!out_full) else begin
                    $display("Output write in test %s while the buffer was full", test_name);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("Test %s wrote more results than its windows allow", test_name);
                    errors++;
                end else begin
                    exp_val = exp_q.pop_front();
                    assert (out_data == exp_val) else begin
                        $display("MISMATCH %s: result %0d expected 0x%06h actual 0x%06h",
                                 test_name, n_writes, exp_val, out_data);
                        errors++;
                    end
                end
            end
            if (full_done) begin
                n_done++;
                // All taps are issued by the last write
                assert (out_wr && exp_q.size() == 0 && !stride_count_flag) else begin
                    $display("full_done in test %s did not mark the last write of the run",
                             test_name);
                    errors++;
                end
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errs_before, input int n_results);
        tests_run++;
        if (errors == errs_before) begin
            $display("PASS %s: %0d results", name, n_results);
        end else begin
            tests_failed++;
            $display("FAIL %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic check_idle_outputs();
        int i;
        int errs_before;

        test_name   = "reset_idle";
        errs_before = errors;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!(ifmap_rd || filt_rd || out_wr || psum_done || full_done
                      || stride_count_flag || u_conv_pe_top.stall
                      || u_conv_pe_top.if_ready || u_conv_pe_top.filt_ready)) else begin
                $display("Control output high after reset with no start pulse, cycle %0d", i);
                errors++;
            end
        end
        report_test(test_name, errs_before, 0);
    endtask

    task automatic run_conv(input string name, input int n_if, input int flen,
                            input int strd, input logic add_psum, input logic bp,
                            input logic gaps);
        int   n_exp;
        int   k;
        int   j;
        int   sum;
        int   cycles;
        int   errs_before;
        int   writes_before;
        int   done_before;
        logic saw_run;
        acc_t psum;

        @(posedge clk);
        test_name    = name;
        starve       = gaps;
        backpressure = bp;
        psum         = acc_t'($urandom_range(0, 32'h00ff_ffff));
        for (k = 0; k < n_if; k++) begin
            if_mem[k] = data_t'($urandom_range(0, 255));
            if_q.push_back(if_mem[k]);
        end
        for (j = 0; j < flen; j++) begin
            filt_mem[j] = coef_t'($urandom_range(0, 255));
            filt_q.push_back(filt_mem[j]);
        end

        @(negedge clk);
        // Window count and sliding dot products
        n_exp = (n_if < flen) ? 0 : (n_if - flen) / strd + 1;
        for (k = 0; k < n_exp; k++) begin
            sum = add_psum ? int'(psum) : 0;
            for (j = 0; j < flen; j++) begin
                sum += int'(if_mem[k * strd + j]) * int'(filt_mem[j]);
            end
            exp_q.push_back(acc_t'(sum));
        end
        errs_before   = errors;
        writes_before = n_writes;
        done_before   = n_done;
        saw_run       = 1'b0;
        filt_len      = filt_addr_t'(flen);
        stride        = if_addr_t'(strd);
        psum_in       = psum;
        psum_add_en   = add_psum;
        ifmap_start   = 1'b1;
        filt_start    = 1'b1;
        conv_start    = 1'b1;
        @(negedge clk);
        ifmap_start = 1'b0;
        filt_start  = 1'b0;
        conv_start  = 1'b0;

        cycles = 0;
        while (n_done == done_before && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            saw_run = saw_run | stride_count_flag;
            cycles++;
        end
        if (n_done == done_before) begin
            abort_on_timeout("full_done");
        end
        // Quiet period where nothing more may be written
        repeat (10) @(negedge clk);

        assert (n_writes - writes_before == n_exp) else begin
            $display("MISMATCH %s: results expected %0d actual %0d",
                     name, n_exp, n_writes - writes_before);
            errors++;
        end
        assert (n_done - done_before == 1) else begin
            $display("MISMATCH %s: full_done pulses expected 1 actual %0d",
                     name, n_done - done_before);
            errors++;
        end
        assert (saw_run) else begin
            $display("stride_count_flag never rose during test %s", name);
            errors++;
        end
        exp_q.delete();
        report_test(name, errs_before, n_writes - writes_before);
    endtask

    initial begin
        void'($urandom(30102));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        starve       = 1'b0;
        backpressure = 1'b0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_idle_outputs();
        run_conv("stride_1", 8, 3, 1, 1'b0, 1'b0, 1'b0);
        run_conv("stride_2", 13, 4, 2, 1'b0, 1'b0, 1'b0);
        run_conv("psum_add", 10, 3, 1, 1'b1, 1'b0, 1'b0);
        run_conv("backpressure", 20, 5, 3, 1'b0, 1'b1, 1'b0);
        run_conv("starved", 16, 4, 1, 1'b0, 1'b0, 1'b1);
        run_conv("mixed", 40, 7, 2, 1'b1, 1'b1, 1'b1);

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
